// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_pc2drone -Mdir obj_dir
	./obj_dir/Vtb_pc2drone | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/control_if.sv ====
// *************************************************
// Decoded command and telemetry frames
// Decoders drive, flight control reads
// *************************************************
`timescale 1ns/1ps

interface control_if;
    import pc2drone_pkg::*;

    // Command path
    logic             cmd_valid;
    command_frame_t   cmd;

    // Telemetry path
    logic             tlm_valid;
    telemetry_frame_t tlm;

    // Command decoder side
    modport cmd_src (output cmd_valid, output cmd);

    // Telemetry decoder side
    modport tlm_src (output tlm_valid, output tlm);

    // Flight control side
    modport sink (input cmd_valid, input cmd, input tlm_valid, input tlm);

endinterface

// ==== design/flight_control.sv ====
// *************************************************
// Execute stage, three PID loops and open-loop yaw
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module flight_control (
    input  logic                      clk_system,
    input  logic                      rst,
    control_if.sink                   ctrl,
    output logic                      orders_valid,
    output pc2drone_pkg::ppm_orders_t orders
);
    import pc2drone_pkg::*;

    command_frame_t cmd_q;
    ppm_order_t     yaw_order;
    ppm_order_t     yaw_sum;
    ppm_order_t     alt_order;
    ppm_order_t     front_order;
    ppm_order_t     side_order;
    logic           alt_valid;
    logic           front_valid;
    logic           side_valid;

    // Yaw is offset from the low end, no feedback
    assign yaw_sum = `PPM_MIN + {7'b0, ctrl.cmd.yaw_cmd} + {7'b0, ctrl.cmd.yaw_offset};

    // Latest commands and gains
    always_ff @(posedge clk_system) begin
        if (rst) begin
            cmd_q     <= '0;
            yaw_order <= `PPM_MID;
        end else if (ctrl.cmd_valid) begin
            cmd_q     <= ctrl.cmd;
            yaw_order <= (yaw_sum > `PPM_MAX) ? `PPM_MAX : yaw_sum;
        end
    end

    // Altitude loop starts from minimum throttle
    pid_axis #(.CENTERED(1'b0), .BASE(`PPM_MIN)) pid_alt (
        .clk_system (clk_system),
        .rst        (rst),
        .sample_valid (ctrl.tlm_valid),
        .command    (cmd_q.alt_cmd),
        .kp         (cmd_q.alt_kp),
        .ki         (cmd_q.alt_ki),
        .kd         (cmd_q.alt_kd),
        .measurement (ctrl.tlm.altitude),
        .order_valid (alt_valid),
        .order      (alt_order)
    );

    // Horizontal loops share the xy gains
    pid_axis #(.CENTERED(1'b1), .BASE(`PPM_MID)) pid_front (
        .clk_system (clk_system),
        .rst        (rst),
        .sample_valid (ctrl.tlm_valid),
        .command    (cmd_q.front_cmd),
        .kp         (cmd_q.xy_kp),
        .ki         (cmd_q.xy_ki),
        .kd         (cmd_q.xy_kd),
        .measurement (ctrl.tlm.disp_front),
        .order_valid (front_valid),
        .order      (front_order)
    );

    pid_axis #(.CENTERED(1'b1), .BASE(`PPM_MID)) pid_side (
        .clk_system (clk_system),
        .rst        (rst),
        .sample_valid (ctrl.tlm_valid),
        .command    (cmd_q.side_cmd),
        .kp         (cmd_q.xy_kp),
        .ki         (cmd_q.xy_ki),
        .kd         (cmd_q.xy_kd),
        .measurement (ctrl.tlm.disp_side),
        .order_valid (side_valid),
        .order      (side_order)
    );

    // All three loops finish on the same cycle
    assign orders_valid    = alt_valid & front_valid & side_valid;
    assign orders.throttle = alt_order;
    assign orders.side     = side_order;
    assign orders.front    = front_order;
    assign orders.yaw      = yaw_order;

endmodule

// ==== design/frame_decoder.sv ====
// *************************************************
// Frame assembler for any byte-sized payload type
// Sync hunt, XOR checksum, payload publish
// *************************************************
`timescale 1ns/1ps

module frame_decoder #(
    parameter type        payload_t = logic [15:0],
    parameter logic [7:0] SYNC      = 8'h00
) (
    input  logic       clk_system,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       frame_valid,
    output payload_t   frame
);
    localparam int WIDTH  = $bits(payload_t);
    localparam int NBYTES = WIDTH / 8;
    localparam int CW     = $clog2(NBYTES + 1);

    typedef enum logic [1:0] {HUNT, PAYLOAD, CHECK} state_t;

    state_t           state;
    logic [CW-1:0]    byte_cnt;
    logic [7:0]       xor_acc;
    logic [WIDTH-1:0] shreg;

    // Payload shifter, first byte ends in the MSBs
    always_ff @(posedge clk_system) begin
        if (byte_valid && state == PAYLOAD) begin
            shreg <= {shreg[WIDTH-9:0], byte_data};
        end
    end

    always_ff @(posedge clk_system) begin
        if (rst) begin
            state       <= HUNT;
            byte_cnt    <= '0;
            xor_acc     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (byte_valid) begin
                case (state)
                    HUNT: begin
                        byte_cnt <= '0;
                        xor_acc  <= '0;
                        if (byte_data == SYNC) begin
                            state <= PAYLOAD;
                        end
                    end
                    PAYLOAD: begin
                        xor_acc  <= xor_acc ^ byte_data;
                        byte_cnt <= byte_cnt + 1'b1;
                        // Last payload byte, checksum follows
                        if (byte_cnt == CW'(NBYTES - 1)) begin
                            state <= CHECK;
                        end
                    end
                    default: begin
                        // Back to hunting whatever the outcome
                        state <= HUNT;
                        if (byte_data == xor_acc) begin
                            frame_valid <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Published payload only moves on a good checksum
    always_ff @(posedge clk_system) begin
        if (byte_valid && state == CHECK && byte_data == xor_acc) begin
            frame <= payload_t'(shreg);
        end
    end

endmodule

// ==== design/pc2drone.sv ====
// *************************************************
// Ground-to-drone flight controller top level
// UART decode, PID execute, PPM result
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module pc2drone (
    input  logic clk_system,
    input  logic rst,
    input  logic uart_input_pc,
    input  logic uart_input_drone,
    output logic ppm_output
);
    import pc2drone_pkg::*;

    // Receiver to decoder byte streams
    logic        pc_byte_valid;
    logic [7:0]  pc_byte_data;
    logic        drone_byte_valid;
    logic [7:0]  drone_byte_data;

    // Flight control to encoder
    logic        orders_valid;
    ppm_orders_t orders;

    control_if ctrl ();

    // Ground station commands
    uart_rx uart_pc (
        .clk_system (clk_system),
        .rst        (rst),
        .sdin       (uart_input_pc),
        .byte_valid (pc_byte_valid),
        .byte_data  (pc_byte_data)
    );

    frame_decoder #(.payload_t(command_frame_t), .SYNC(`CMD_SYNC)) cmd_decoder (
        .clk_system  (clk_system),
        .rst         (rst),
        .byte_valid  (pc_byte_valid),
        .byte_data   (pc_byte_data),
        .frame_valid (ctrl.cmd_valid),
        .frame       (ctrl.cmd)
    );

    // Drone telemetry
    uart_rx uart_drone (
        .clk_system (clk_system),
        .rst        (rst),
        .sdin       (uart_input_drone),
        .byte_valid (drone_byte_valid),
        .byte_data  (drone_byte_data)
    );

    frame_decoder #(.payload_t(telemetry_frame_t), .SYNC(`TLM_SYNC)) tlm_decoder (
        .clk_system  (clk_system),
        .rst         (rst),
        .byte_valid  (drone_byte_valid),
        .byte_data   (drone_byte_data),
        .frame_valid (ctrl.tlm_valid),
        .frame       (ctrl.tlm)
    );

    flight_control flight_ctrl (
        .clk_system   (clk_system),
        .rst          (rst),
        .ctrl         (ctrl.sink),
        .orders_valid (orders_valid),
        .orders       (orders)
    );

    ppm_encoder ppm_enc (
        .clk_system   (clk_system),
        .rst          (rst),
        .orders_valid (orders_valid),
        .orders       (orders),
        .ppm_output   (ppm_output)
    );

endmodule

// ==== design/pc2drone_params.svh ====
// *************************************************
// Timing and scaling constants for the controller
// UART bit time, sync bytes, PPM timing, PID scaling
// *************************************************
`ifndef PC2DRONE_PARAMS_SVH
`define PC2DRONE_PARAMS_SVH

// Clocks per UART bit, kept small for simulation
`define UART_BIT_CYCLES 8

// Frame sync bytes
`define CMD_SYNC 8'hA5
`define TLM_SYNC 8'h5A

// PPM pulse limits and frame timing, in clocks
`define PPM_MIN   15'd200
`define PPM_MID   15'd400
`define PPM_MAX   15'd600
`define PPM_SEP   15'd40
`define PPM_FRAME 15'd4000

// PID scaling
`define INTEG_LIMIT 4096
`define GAIN_SHIFT  6

`endif

// ==== design/pc2drone_pkg.sv ====
// *************************************************
// Frame and order types shared across the design
// *************************************************
package pc2drone_pkg;

    // Command frame from the ground station, first byte in the MSBs
    typedef struct packed {
        logic [7:0] alt_cmd;
        logic [7:0] side_cmd;
        logic [7:0] front_cmd;
        logic [7:0] yaw_cmd;
        logic [7:0] alt_kp;
        logic [7:0] alt_ki;
        logic [7:0] alt_kd;
        logic [7:0] xy_kp;
        logic [7:0] xy_ki;
        logic [7:0] xy_kd;
        logic [7:0] yaw_offset;
    } command_frame_t;

    // Drone telemetry, each field big endian on the wire
    typedef struct packed {
        logic signed [15:0] disp_front;
        logic signed [15:0] disp_side;
        logic signed [15:0] altitude;
    } telemetry_frame_t;

    // Pulse width in clocks
    typedef logic [14:0] ppm_order_t;

    // Channel order of the PPM train
    typedef struct packed {
        ppm_order_t throttle;
        ppm_order_t side;
        ppm_order_t front;
        ppm_order_t yaw;
    } ppm_orders_t;

endpackage

// ==== design/pid_axis.sv ====
// *************************************************
// Two-stage PID unit for one axis
// Clamped integrator, clamped pulse width output
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module pid_axis #(
    parameter bit          CENTERED = 1'b1,
    parameter logic [14:0] BASE     = `PPM_MID
) (
    input  logic                      clk_system,
    input  logic                      rst,
    input  logic                      sample_valid,
    input  logic [7:0]                command,
    input  logic [7:0]                kp,
    input  logic [7:0]                ki,
    input  logic [7:0]                kd,
    input  logic signed [15:0]        measurement,
    output logic                      order_valid,
    output pc2drone_pkg::ppm_order_t  order
);
    localparam logic signed [18:0] INTEG_MAX = `INTEG_LIMIT;
    localparam logic signed [18:0] INTEG_MIN = -`INTEG_LIMIT;
    localparam logic signed [31:0] LVL_MIN   = `PPM_MIN;
    localparam logic signed [31:0] LVL_MAX   = `PPM_MAX;
    localparam logic signed [31:0] LVL_BASE  = BASE;

    logic signed [18:0] setpoint;
    logic signed [18:0] error;
    logic signed [18:0] integ;
    logic signed [18:0] integ_sum;
    logic signed [18:0] integ_next;
    logic signed [18:0] prev_err;
    logic signed [18:0] deriv;
    logic signed [31:0] p_term;
    logic signed [31:0] i_term;
    logic signed [31:0] d_term;
    logic signed [31:0] level;
    logic               prod_valid;

    // Horizontal commands are centered on 128
    assign setpoint = CENTERED ? $signed({11'b0, command}) - 19'sd128
                               : $signed({11'b0, command});
    assign error    = setpoint - measurement;
    assign deriv    = error - prev_err;

    // Saturating integrator
    assign integ_sum  = integ + error;
    assign integ_next = (integ_sum > INTEG_MAX) ? INTEG_MAX :
                        (integ_sum < INTEG_MIN) ? INTEG_MIN : integ_sum;

    // Stage 1 products and state update
    always_ff @(posedge clk_system) begin
        if (rst) begin
            integ      <= '0;
            prev_err   <= '0;
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= sample_valid;
            if (sample_valid) begin
                integ    <= integ_next;
                prev_err <= error;
            end
        end
    end

    always_ff @(posedge clk_system) begin
        if (sample_valid) begin
            p_term <= $signed({1'b0, kp}) * error;
            i_term <= $signed({1'b0, ki}) * integ_next;
            d_term <= $signed({1'b0, kd}) * deriv;
        end
    end

    // Stage 2 sum, scale, offset
    assign level = ((p_term + i_term + d_term) >>> `GAIN_SHIFT) + LVL_BASE;

    always_ff @(posedge clk_system) begin
        if (rst) begin
            order_valid <= 1'b0;
        end else begin
            order_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk_system) begin
        if (prod_valid) begin
            if (level < LVL_MIN) begin
                order <= `PPM_MIN;
            end else if (level > LVL_MAX) begin
                order <= `PPM_MAX;
            end else begin
                order <= level[14:0];
            end
        end
    end

endmodule

// ==== design/ppm_encoder.sv ====
// *************************************************
// Four-channel PPM pulse train generator
// Orders picked up at each frame start
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module ppm_encoder (
    input  logic                      clk_system,
    input  logic                      rst,
    input  logic                      orders_valid,
    input  pc2drone_pkg::ppm_orders_t orders,
    output logic                      ppm_output
);
    import pc2drone_pkg::*;

    ppm_orders_t pending;
    ppm_orders_t working;
    ppm_order_t  cur_width;
    logic [14:0] frame_cnt;
    logic [14:0] seg_cnt;
    logic [2:0]  ch;
    logic        in_sep;

    // Latest orders wait here until the next frame
    always_ff @(posedge clk_system) begin
        if (rst) begin
            pending.throttle <= `PPM_MIN;
            pending.side     <= `PPM_MID;
            pending.front    <= `PPM_MID;
            pending.yaw      <= `PPM_MID;
        end else if (orders_valid) begin
            pending <= orders;
        end
    end

    // Width of the channel being sent
    always_comb begin
        case (ch)
            3'd0:    cur_width = working.throttle;
            3'd1:    cur_width = working.side;
            3'd2:    cur_width = working.front;
            3'd3:    cur_width = working.yaw;
            default: cur_width = `PPM_FRAME;
        endcase
    end

    always_ff @(posedge clk_system) begin
        if (rst) begin
            // Parked at frame end so the first frame starts right after reset
            frame_cnt  <= `PPM_FRAME - 15'd1;
            seg_cnt    <= '0;
            ch         <= 3'd4;
            in_sep     <= 1'b0;
            ppm_output <= 1'b1;
        end else if (frame_cnt == `PPM_FRAME - 15'd1) begin
            frame_cnt  <= '0;
            seg_cnt    <= '0;
            ch         <= 3'd0;
            in_sep     <= 1'b1;
            ppm_output <= 1'b0;
        end else begin
            frame_cnt <= frame_cnt + 15'd1;
            if (in_sep) begin
                // Low separator before each channel and before the sync gap
                if (seg_cnt == `PPM_SEP - 15'd1) begin
                    seg_cnt    <= '0;
                    in_sep     <= 1'b0;
                    ppm_output <= 1'b1;
                end else begin
                    seg_cnt <= seg_cnt + 15'd1;
                end
            end else if (ch != 3'd4) begin
                // High part of a channel, separator counts toward its width
                if (seg_cnt == cur_width - `PPM_SEP - 15'd1) begin
                    seg_cnt    <= '0;
                    in_sep     <= 1'b1;
                    ppm_output <= 1'b0;
                    ch         <= ch + 3'd1;
                end else begin
                    seg_cnt <= seg_cnt + 15'd1;
                end
            end
        end
    end

    // Working set refreshed only at frame start
    always_ff @(posedge clk_system) begin
        if (frame_cnt == `PPM_FRAME - 15'd1) begin
            working <= pending;
        end
    end

endmodule

// ==== design/uart_rx.sv ====
// *************************************************
// 8N1 UART receiver with input synchronizer
// One byte per valid pulse, framing errors dropped
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module uart_rx (
    input  logic       clk_system,
    input  logic       rst,
    input  logic       sdin,
    output logic       byte_valid,
    output logic [7:0] byte_data
);
    localparam int BIT  = `UART_BIT_CYCLES;
    localparam int HALF = BIT / 2;
    localparam int CW   = $clog2(BIT) + 1;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t        state;
    logic [1:0]    sync;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          line;

    // Synchronized serial line
    assign line = sync[1];

    always_ff @(posedge clk_system) begin
        if (rst) begin
            sync       <= 2'b11;
            state      <= IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            sync       <= {sync[0], sdin};
            byte_valid <= 1'b0;
            case (state)
                IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // Falling edge, possible start bit
                    if (!line) begin
                        state <= START;
                    end
                end
                START: begin
                    if (cnt == CW'(HALF - 1)) begin
                        cnt <= '0;
                        // Glitch if line went back high by mid bit
                        state <= line ? IDLE : DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (cnt == CW'(BIT - 1)) begin
                        cnt <= '0;
                        // LSB first
                        byte_data <= {line, byte_data[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CW'(BIT - 1)) begin
                        cnt   <= '0;
                        state <= IDLE;
                        // Low stop bit is a framing error
                        byte_valid <= line;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== list.f ====
+incdir+design
design/pc2drone_pkg.sv
design/control_if.sv
design/uart_rx.sv
design/frame_decoder.sv
design/pid_axis.sv
design/flight_control.sv
design/ppm_encoder.sv
design/pc2drone.sv
verification/tb_pc2drone.sv

// ==== verification/tb_pc2drone.sv ====
// *************************************************
// Self-checking testbench for the flight controller
// UART drivers, PID reference model, PPM measurer
// *************************************************
`timescale 1ns/1ps
`include "pc2drone_params.svh"

module tb_pc2drone;
    import pc2drone_pkg::*;

    localparam int BIT     = `UART_BIT_CYCLES;
    localparam int W_MIN   = `PPM_MIN;
    localparam int W_MID   = `PPM_MID;
    localparam int W_MAX   = `PPM_MAX;
    localparam int W_SEP   = `PPM_SEP;
    localparam int W_FRAME = `PPM_FRAME;
    localparam int NUM_FRAMES = 30;
    localparam int NUM_CHECKS = 20;
    // Longest frame is sync, 11 bytes, checksum and one spare byte
    localparam int FRAME_BITS   = 14 * 10;
    localparam int LIMIT_CYCLES = 2 * (NUM_FRAMES * FRAME_BITS * BIT
                                       + NUM_CHECKS * 3 * W_FRAME);

    logic clk_system;
    logic rst;
    logic uart_input_pc;
    logic uart_input_drone;
    logic ppm_output;

    integer seed;

    // Model state, widths ordered throttle, side, front, yaw
    command_frame_t held_cmd;
    int             held_yaw;
    int             integ [3];
    int             prev_err [3];
    int             exp_w [4];
    int             meas_w [4];

    pc2drone DUT (
        .clk_system       (clk_system),
        .rst              (rst),
        .uart_input_pc    (uart_input_pc),
        .uart_input_drone (uart_input_drone),
        .ppm_output       (ppm_output)
    );

    initial begin
        clk_system = 1'b0;
        forever #50 clk_system = ~clk_system;
    end

    // Bound on frames sent plus PPM frames per check
    initial begin
        #(LIMIT_CYCLES * 100);
        $display("Timeout: tests did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int clamp_width(input int level);
        if (level < W_MIN) begin
            return W_MIN;
        end
        return (level > W_MAX) ? W_MAX : level;
    endfunction

    // One PID step: error, saturated integrator, derivative, scaled sum
    task automatic model_axis(input int axis, input int command, input int kp, input int ki,
                              input int kd, input int meas, input bit centered,
                              input int base, output int order);
        int setpoint;
        int error;
        int deriv;
        int sum;
        setpoint = centered ? command - 128 : command;
        error = setpoint - meas;
        integ[axis] = integ[axis] + error;
        if (integ[axis] > `INTEG_LIMIT) begin
            integ[axis] = `INTEG_LIMIT;
        end else if (integ[axis] < -`INTEG_LIMIT) begin
            integ[axis] = -`INTEG_LIMIT;
        end
        deriv = error - prev_err[axis];
        prev_err[axis] = error;
        sum = kp * error + ki * integ[axis] + kd * deriv;
        order = clamp_width(base + (sum >>> `GAIN_SHIFT));
    endtask

    task automatic model_command(input command_frame_t f);
        int sum;
        held_cmd = f;
        sum = W_MIN + int'(f.yaw_cmd) + int'(f.yaw_offset);
        held_yaw = (sum > W_MAX) ? W_MAX : sum;
    endtask

    // Yaw only reaches the encoder together with a telemetry update
    task automatic model_telemetry(input telemetry_frame_t t);
        model_axis(0, held_cmd.alt_cmd, held_cmd.alt_kp, held_cmd.alt_ki, held_cmd.alt_kd,
                   t.altitude, 1'b0, W_MIN, exp_w[0]);
        model_axis(1, held_cmd.side_cmd, held_cmd.xy_kp, held_cmd.xy_ki, held_cmd.xy_kd,
                   t.disp_side, 1'b1, W_MID, exp_w[1]);
        model_axis(2, held_cmd.front_cmd, held_cmd.xy_kp, held_cmd.xy_ki, held_cmd.xy_kd,
                   t.disp_front, 1'b1, W_MID, exp_w[2]);
        exp_w[3] = held_yaw;
    endtask

    task automatic drive_line(input bit to_drone, input logic value, input int cycles);
        repeat (cycles) begin
            @(posedge clk_system);
            if (to_drone) begin
                uart_input_drone <= value;
            end else begin
                uart_input_pc <= value;
            end
        end
    endtask

    // 8N1, LSB first; optional low stop bit then idle line
    task automatic send_byte(input bit to_drone, input logic [7:0] data, input bit low_stop);
        logic [9:0] bits;
        bits = {~low_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            drive_line(to_drone, bits[i], BIT);
        end
        if (low_stop) begin
            drive_line(to_drone, 1'b1, 2 * BIT);
        end
    endtask

    task automatic send_command(input command_frame_t f, input bit bad_sum);
        logic [87:0] raw;
        logic [7:0]  sum;
        raw = f;
        sum = 8'h00;
        send_byte(1'b0, `CMD_SYNC, 1'b0);
        for (int i = 10; i >= 0; i--) begin
            sum = sum ^ raw[i*8 +: 8];
            send_byte(1'b0, raw[i*8 +: 8], 1'b0);
        end
        send_byte(1'b0, bad_sum ? ~sum : sum, 1'b0);
    endtask

    task automatic send_telemetry(input telemetry_frame_t t, input bit bad_stop);
        logic [47:0] raw;
        logic [7:0]  sum;
        raw = t;
        sum = 8'h00;
        send_byte(1'b1, `TLM_SYNC, 1'b0);
        for (int i = 5; i >= 0; i--) begin
            sum = sum ^ raw[i*8 +: 8];
            send_byte(1'b1, raw[i*8 +: 8], 1'b0);
        end
        send_byte(1'b1, sum, bad_stop);
        // Decoder still waits for a checksum, give it a wrong one
        if (bad_stop) begin
            send_byte(1'b1, ~sum, 1'b0);
        end
    endtask

    task automatic send_garbage(input bit to_drone, input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            if (r[7:0] == `CMD_SYNC || r[7:0] == `TLM_SYNC) begin
                r[7:0] = 8'h00;
            end
            send_byte(to_drone, r[7:0], 1'b0);
        end
    endtask

    task automatic random_command(input logic [7:0] gain_mask, output command_frame_t f);
        logic [87:0] raw;
        logic [31:0] r;
        for (int i = 0; i < 11; i++) begin
            r = $random(seed);
            raw[i*8 +: 8] = r[7:0];
        end
        f = raw;
        f.alt_kp &= gain_mask;
        f.alt_ki &= gain_mask;
        f.alt_kd &= gain_mask;
        f.xy_kp  &= gain_mask;
        f.xy_ki  &= gain_mask;
        f.xy_kd  &= gain_mask;
    endtask

    // Measurements spread over -span..span
    task automatic random_telemetry(input int span, output telemetry_frame_t t);
        int r;
        r = $random(seed);
        t.disp_front = 16'(r % span);
        r = $random(seed);
        t.disp_side = 16'(r % span);
        r = $random(seed);
        t.altitude = 16'(r % span);
    endtask

    // Falling edge to falling edge, entered on the first low sample
    task automatic ppm_interval(output int len, output int low_len);
        logic prev;
        logic done;
        len = 1;
        low_len = 1;
        prev = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_system);
            if (prev && !ppm_output) begin
                done = 1'b1;
            end else begin
                len++;
                if (!ppm_output) begin
                    low_len++;
                end
                prev = ppm_output;
            end
        end
    endtask

    // Long sync gap marks the next frame start
    task automatic align_frame();
        int   len;
        int   low_len;
        logic prev;
        @(negedge clk_system);
        prev = ppm_output;
        while (!(prev && !ppm_output) || prev === 1'bx) begin
            prev = ppm_output;
            @(negedge clk_system);
        end
        len = 0;
        while (len <= W_MAX) begin
            ppm_interval(len, low_len);
        end
    endtask

    task automatic measure_frame();
        int len;
        int low_len;
        int total;
        total = 0;
        for (int ch = 0; ch < 5; ch++) begin
            ppm_interval(len, low_len);
            check_value("ppm separator", low_len, W_SEP);
            if (ch < 4) begin
                meas_w[ch] = len;
            end
            total += len;
        end
        check_value("ppm frame length", total, W_FRAME);
    endtask

    // First full frame may still hold the old orders
    task automatic check_orders();
        align_frame();
        measure_frame();
        measure_frame();
        check_value("throttle width", meas_w[0], exp_w[0]);
        check_value("side width", meas_w[1], exp_w[1]);
        check_value("front width", meas_w[2], exp_w[2]);
        check_value("yaw width", meas_w[3], exp_w[3]);
    endtask

    initial begin
        command_frame_t   cf;
        telemetry_frame_t tf;
        seed = 32'h9cf0_1434;
        rst = 1'b1;
        uart_input_pc = 1'b1;
        uart_input_drone = 1'b1;
        held_cmd = '0;
        held_yaw = W_MID;
        exp_w = '{W_MIN, W_MID, W_MID, W_MID};
        integ = '{0, 0, 0};
        prev_err = '{0, 0, 0};
        repeat (4) @(posedge clk_system);
        rst <= 1'b0;

        // Reset defaults
        check_orders();

        // Open-loop yaw, carried out by a telemetry update
        for (int i = 0; i < 4; i++) begin
            random_command(8'hFF, cf);
            send_command(cf, 1'b0);
            model_command(cf);
            random_telemetry(64, tf);
            send_telemetry(tf, 1'b0);
            model_telemetry(tf);
            check_orders();
        end

        // Closed loop with small gains, integrator and derivative history
        random_command(8'h07, cf);
        send_command(cf, 1'b0);
        model_command(cf);
        for (int i = 0; i < 8; i++) begin
            random_telemetry(64, tf);
            send_telemetry(tf, 1'b0);
            model_telemetry(tf);
            check_orders();
        end

        // Saturation, full gains and large errors both ways
        random_command(8'hFF, cf);
        cf = {8'd128, 8'd128, 8'd128, cf.yaw_cmd, {6{8'hFF}}, cf.yaw_offset};
        send_command(cf, 1'b0);
        model_command(cf);
        for (int i = 0; i < 4; i++) begin
            tf.disp_front = (i < 2) ? -16'sd30000 : 16'sd30000;
            tf.disp_side  = tf.disp_front;
            tf.altitude   = tf.disp_front;
            send_telemetry(tf, 1'b0);
            model_telemetry(tf);
            check_orders();
            for (int a = 0; a < 3; a++) begin
                check_value("model integrator", integ[a],
                            (i < 2) ? `INTEG_LIMIT : -`INTEG_LIMIT);
                check_value("saturated width", exp_w[a], (i < 2) ? W_MAX : W_MIN);
            end
        end

        // Held yaw pushed to the far end, so any taken telemetry shows up
        random_command(8'h07, cf);
        cf.yaw_cmd    = (held_yaw > W_MID) ? 8'd0 : 8'd255;
        cf.yaw_offset = cf.yaw_cmd;
        send_command(cf, 1'b0);
        model_command(cf);

        // Corrupt frames leave orders and model untouched
        cf.yaw_cmd    = ~cf.yaw_cmd;
        cf.yaw_offset = cf.yaw_cmd;
        send_command(cf, 1'b1);
        random_telemetry(64, tf);
        send_telemetry(tf, 1'b1);
        check_orders();

        // Next good telemetry still runs on the last good command
        random_telemetry(64, tf);
        send_telemetry(tf, 1'b0);
        model_telemetry(tf);
        check_orders();

        // Garbage without sync bytes, then valid frames
        send_garbage(1'b0, 12);
        random_command(8'h07, cf);
        send_command(cf, 1'b0);
        model_command(cf);
        send_garbage(1'b1, 12);
        random_telemetry(64, tf);
        send_telemetry(tf, 1'b0);
        model_telemetry(tf);
        check_orders();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
